/* spi_fifo_tx.f */
logic/spi_fifo_pkg.sv
logic/tx_fifo.sv
logic/sclk_gen.sv
logic/spi_serializer.sv
logic/spi_fifo_tx.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_spi_fifo_tx.sv

/* run_sim.sh */
#!/bin/sh
# Builds the SPI transmitter testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_spi_fifo_tx \
    -f spi_fifo_tx.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "All checks passed" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

/* sim/tb_spi_fifo_tx.sv */
/*
 * Testbench top for the FIFO-fed SPI transmitter.
 * Inputs change on the falling clock edge only. A write counts as accepted
 * when full is low at the edge where it is driven.
 * A watchdog ends the run if the words do not arrive in time.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_spi_fifo_tx;

    import spi_fifo_pkg::*;

    localparam int RESET_CYCLES    = 10;
    localparam int ORDER_WORDS     = 6;
    localparam int BURST_WRITES    = FIFO_DEPTH + 4;
    localparam int TOTAL_WORDS     = 1 + ORDER_WORDS + BURST_WRITES;
    localparam int CLOCKS_PER_WORD = 50;
    localparam int MARGIN_CYCLES   = 400;
    localparam int CLK_PERIOD_NS   = 8;

    logic  clk;
    logic  rst;
    logic  wr_en;
    data_t wr_data;
    logic  full;
    logic  empty;
    logic  sclk;
    logic  mosi;
    logic  done;

    int   tb_errors;
    int   checker_errors;
    int   quiet_errors;
    int   words_seen;
    int   expected_words;
    int   errors_before_test;
    int   burst_start;
    int   tests_run;
    logic saw_full;

    tb_clock i_clock (
        .clk (clk)
    );

    spi_fifo_tx i_dut (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .full    (full),
        .empty   (empty),
        .sclk    (sclk),
        .mosi    (mosi),
        .done    (done)
    );

    tb_checker i_checker (
        .clk          (clk),
        .rst          (rst),
        .sclk         (sclk),
        .mosi         (mosi),
        .done         (done),
        .error_count  (checker_errors),
        .quiet_errors (quiet_errors),
        .word_count   (words_seen)
    );

    function automatic int total_errors();
        return tb_errors + checker_errors;
    endfunction

    // drives one write for a single cycle, called on a falling edge
    task automatic write_word(input data_t word);
        wr_en   = 1'b1;
        wr_data = word;
        if (full) begin
            saw_full = 1'b1;
        end else begin
            i_checker.record_write(word);
            expected_words = expected_words + 1;
        end
        @(negedge clk);
    endtask

    task automatic wait_for_words(input int target);
        while (words_seen < target) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic check_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH %s expected 0x%0h got 0x%0h", name, expected, actual);
            tb_errors = tb_errors + 1;
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = total_errors() - errors_before_test;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errs);
        end
        errors_before_test = total_errors();
        tests_run = tests_run + 1;
    endtask

    // watchdog sized by the number of words sent over the whole run
    initial begin
        #((TOTAL_WORDS * CLOCKS_PER_WORD + MARGIN_CYCLES) * CLK_PERIOD_NS);
        $display("timeout: the DUT did not finish sending all words in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(84891));
        rst                = 1'b1;
        wr_en              = 1'b0;
        wr_data            = '0;
        tb_errors          = 0;
        expected_words     = 0;
        errors_before_test = 0;
        burst_start        = 0;
        tests_run          = 0;
        saw_full           = 1'b0;

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // idle after reset, the line must stay low while nothing is written
        @(negedge clk);
        check_level("empty", empty, 1'b1);
        check_level("full", full, 1'b0);
        repeat (20) begin
            @(negedge clk);
            check_level("sclk", sclk, 1'b0);
            check_level("mosi", mosi, 1'b0);
            check_level("done", done, 1'b0);
        end
        if (words_seen != 0) begin
            $display("done pulsed while nothing was written");
            tb_errors = tb_errors + 1;
        end
        report_test("reset");

        write_word(data_t'($urandom));
        wr_en = 1'b0;
        wait_for_words(expected_words);
        report_test("single word");

        for (int i = 0; i < ORDER_WORDS; i++) begin
            write_word(data_t'($urandom));
        end
        wr_en = 1'b0;
        wait_for_words(expected_words);
        check_level("empty", empty, 1'b1);
        report_test("ordering");

        // back to back writes outrun the serializer by far
        saw_full    = 1'b0;
        burst_start = expected_words;
        for (int i = 0; i < BURST_WRITES; i++) begin
            write_word(data_t'($urandom));
        end
        wr_en = 1'b0;
        if (!saw_full) begin
            $display("full never went high during a burst larger than the FIFO");
            tb_errors = tb_errors + 1;
        end
        // an empty FIFO takes FIFO_DEPTH words plus the one popped three cycles into the burst
        if (expected_words - burst_start != FIFO_DEPTH + 1) begin
            $display("MISMATCH accepted_writes expected 0x%0h got 0x%0h",
                     FIFO_DEPTH + 1, expected_words - burst_start);
            tb_errors = tb_errors + 1;
        end
        wait_for_words(expected_words);
        check_level("empty", empty, 1'b1);
        if (words_seen != expected_words) begin
            $display("MISMATCH done_count expected 0x%0h got 0x%0h",
                     expected_words, words_seen);
            tb_errors = tb_errors + 1;
        end
        report_test("full flag and drops");

        $display("test line quiet: %0d gap violations over all words", quiet_errors);
        tests_run = tests_run + 1;

        $display("summary: %0d tests, %0d words, %0d errors",
                 tests_run, words_seen, total_errors());
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_checker.sv */
/*
 * Watches the top-level ports of the SPI transmitter.
 * Samples everything on the falling clock edge, where all DUT outputs are stable.
 * Words are rebuilt from mosi at each sclk rise, MSB first, and compared
 * with the accepted writes in order. The writer side fills the queue
 * through record_write.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
    input  logic clk,
    input  logic rst,
    input  logic sclk,
    input  logic mosi,
    input  logic done,
    output int   error_count,
    output int   quiet_errors,
    output int   word_count
);

    import spi_fifo_pkg::*;

    // writes that the FIFO accepted, oldest first
    data_t accepted_words[$];

    data_t rx_word;
    data_t exp_word;
    int    rise_count;
    int    gap_cycles;
    logic  in_gap;
    logic  sclk_prev;
    logic  done_prev;

    task automatic record_write(input data_t word);
        accepted_words.push_back(word);
    endtask

    // the next word on the line must be the oldest accepted write
    function automatic data_t expected_word();
        data_t word;
        word = accepted_words.pop_front();
        return word;
    endfunction

    initial begin
        error_count  = 0;
        quiet_errors = 0;
        word_count   = 0;
    end

    always @(negedge clk) begin
        if (rst) begin
            rx_word    = '0;
            rise_count = 0;
            gap_cycles = 3;
            in_gap     = 1'b1;
            sclk_prev  = 1'b0;
            done_prev  = 1'b0;
        end else begin
            // a rising sclk ends any quiet gap and carries one bit
            if (sclk && !sclk_prev) begin
                rx_word    = {rx_word[DATA_WIDTH-2:0], mosi};
                rise_count = rise_count + 1;
                in_gap     = 1'b0;
            end
            if (in_gap) begin
                if (sclk) begin
                    $display("sclk went high between words without a rising edge sample");
                    error_count  = error_count + 1;
                    quiet_errors = quiet_errors + 1;
                end
                // shifting cannot start before three cycles after done
                if (gap_cycles < 2 && mosi) begin
                    $display("MISMATCH mosi expected 0x0 got 0x%0h between words", mosi);
                    error_count  = error_count + 1;
                    quiet_errors = quiet_errors + 1;
                end
                if (gap_cycles < 3) begin
                    gap_cycles = gap_cycles + 1;
                end
            end
            if (done && done_prev) begin
                $display("done stayed high for more than one cycle");
                error_count = error_count + 1;
            end else if (done) begin
                if (sclk || mosi) begin
                    $display("MISMATCH sclk/mosi expected 0x0/0x0 got 0x%0h/0x%0h at done",
                             sclk, mosi);
                    error_count  = error_count + 1;
                    quiet_errors = quiet_errors + 1;
                end
                if (accepted_words.size() == 0) begin
                    $display("done pulsed although no accepted word was outstanding");
                    error_count = error_count + 1;
                end else begin
                    exp_word = expected_word();
                    if (rx_word !== exp_word) begin
                        $display("MISMATCH mosi_word expected 0x%0h got 0x%0h",
                                 exp_word, rx_word);
                        error_count = error_count + 1;
                    end
                end
                if (rise_count != DATA_WIDTH) begin
                    $display("MISMATCH sclk_rises expected 0x%0h got 0x%0h",
                             DATA_WIDTH, rise_count);
                    error_count = error_count + 1;
                end
                word_count = word_count + 1;
                rise_count = 0;
                rx_word    = '0;
                in_gap     = 1'b1;
                gap_cycles = 0;
            end
            sclk_prev = sclk;
            done_prev = done;
        end
    end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
/*
 * Free running clock for the testbench, 8 ns period.
 * Starts low at time zero.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // half of the 8 ns period
    localparam realtime HALF_PERIOD = 4ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

/* logic/spi_fifo_tx.sv */
/*
 * FIFO-fed SPI transmitter, top level.
 * The writer pulses wr_en for one cycle per word and must watch full,
 * since writes while full are dropped without notice.
 * sclk idles low and mosi changes on its falling edge (SPI mode 0).
 * done pulses once per word after its last bit.
 */
`timescale 1ns/100ps
`default_nettype none

module spi_fifo_tx (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wr_en,
    input  logic [spi_fifo_pkg::DATA_WIDTH-1:0] wr_data,
    output logic                              full,
    output logic                              empty,
    output logic                              sclk,
    output logic                              mosi,
    output logic                              done
);

    import spi_fifo_pkg::*;

    // FIFO read side towards the serializer
    data_t read_data;
    logic  read_en;

    // link between the serializer and the serial clock generator
    logic sclk_enable;
    logic sclk_fall;

    tx_fifo i_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .read_en   (read_en),
        .read_data (read_data),
        .full      (full),
        .empty     (empty)
    );

    sclk_gen i_sclk_gen (
        .clk         (clk),
        .rst         (rst),
        .sclk_enable (sclk_enable),
        .sclk        (sclk),
        .sclk_fall   (sclk_fall)
    );

    spi_serializer i_serializer (
        .clk         (clk),
        .rst         (rst),
        .empty       (empty),
        .read_data   (read_data),
        .sclk_fall   (sclk_fall),
        .read_en     (read_en),
        .sclk_enable (sclk_enable),
        .mosi        (mosi),
        .done        (done)
    );

endmodule

`default_nettype wire

/* logic/spi_serializer.sv */
/*
 * SPI serializer FSM, the consumer side of the transmit FIFO.
 * Sequence per word is idle, read-enable, load, shift and complete.
 * The word is shifted MSB first, one bit per sclk period, and mosi
 * changes on the edge where sclk falls, so it is stable at every rise.
 * There is no back-pressure. The next word starts as soon as the FSM
 * is back in idle and the FIFO is not empty.
 */
`timescale 1ns/100ps
`default_nettype none

module spi_serializer (
    input  logic                clk,
    input  logic                rst,
    input  logic                empty,
    input  spi_fifo_pkg::data_t read_data,
    input  logic                sclk_fall,
    output logic                read_en,
    output logic                sclk_enable,
    output logic                mosi,
    output logic                done
);

    import spi_fifo_pkg::*;

    serializer_state_t state;
    serializer_state_t next_state;

    // payload being shifted out, MSB goes first
    data_t shift_reg;

    // bits still to be sent in the current word
    logic [BIT_COUNT_WIDTH-1:0] bit_count;

    // state register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // next state logic
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                // any word waiting in the FIFO starts a transfer
                if (!empty) begin
                    next_state = ST_READ_EN;
                end
            end
            ST_READ_EN: begin
                next_state = ST_LOAD;
            end
            ST_LOAD: begin
                next_state = ST_SHIFT;
            end
            ST_SHIFT: begin
                // the counter reaches 0 on the last falling sclk edge
                if (bit_count == '0) begin
                    next_state = ST_COMPLETE;
                end
            end
            ST_COMPLETE: begin
                next_state = ST_IDLE;
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // the pop strobe is registered so that it lines up with the load state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_en <= 1'b0;
        end else begin
            read_en <= (state == ST_READ_EN);
        end
    end

    // enable for the serial clock covers exactly the shift state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk_enable <= 1'b0;
        end else begin
            sclk_enable <= (next_state == ST_SHIFT);
        end
    end

    // head word is captured at the same edge that pops it from the FIFO
    always_ff @(posedge clk) begin
        if (state == ST_LOAD) begin
            shift_reg <= read_data;
        end else if ((state == ST_SHIFT) && sclk_fall) begin
            shift_reg <= {shift_reg[DATA_WIDTH-2:0], 1'b0};
        end
    end

    // counter is loaded with the word length and counts falling sclk edges
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_count <= '0;
        end else if (state == ST_LOAD) begin
            bit_count <= BIT_COUNT_WIDTH'(DATA_WIDTH);
        end else if ((state == ST_SHIFT) && sclk_fall && (bit_count != '0)) begin
            bit_count <= bit_count - 1'b1;
        end
    end

    // the line is driven only while shifting and rests low otherwise
    assign mosi = (state == ST_SHIFT) && shift_reg[DATA_WIDTH-1];

    // done pulses for the single cycle after the complete state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= (state == ST_COMPLETE);
        end
    end

endmodule

`default_nettype wire

/* logic/sclk_gen.sv */
/*
 * Serial clock generator.
 * clk_div toggles on every clock, and sclk toggles on the edge that
 * follows a cycle with clk_div high, so one sclk period is 4 clocks.
 * sclk parks low one clock after sclk_enable drops.
 * sclk_fall is combinational and marks the cycle whose closing edge
 * takes sclk from 1 to 0.
 */
`timescale 1ns/100ps
`default_nettype none

module sclk_gen (
    input  logic clk,
    input  logic rst,
    input  logic sclk_enable,
    output logic sclk,
    output logic sclk_fall
);

    // free running divide-by-two phase
    logic clk_div;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_div <= 1'b0;
        end else begin
            clk_div <= ~clk_div;
        end
    end

    // sclk only moves on the falling phase of the divider while enabled
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk <= 1'b0;
        end else if (!sclk_enable) begin
            // return to the idle level and hold there
            sclk <= 1'b0;
        end else if (clk_div) begin
            sclk <= ~sclk;
        end
    end

    // a high sclk drops at the next edge either through a toggle or by being parked
    assign sclk_fall = sclk && (clk_div || !sclk_enable);

endmodule

`default_nettype wire

/* logic/tx_fifo.sv */
/*
 * First-word-fall-through transmit FIFO.
 * The head entry is visible on read_data whenever empty is low.
 * A write while full is dropped, even if a pop happens in the same cycle.
 * A pop while empty is ignored. The storage array has no reset.
 */
`timescale 1ns/100ps
`default_nettype none

module tx_fifo (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_en,
    input  spi_fifo_pkg::data_t wr_data,
    input  logic                read_en,
    output spi_fifo_pkg::data_t read_data,
    output logic                full,
    output logic                empty
);

    import spi_fifo_pkg::*;

    // storage array, one word per entry
    data_t mem [FIFO_DEPTH];

    // pointers wrap on their own since the depth is a power of two
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;

    // occupancy needs one bit more than the pointers to tell full from empty
    logic [ADDR_WIDTH:0] count;

    // accepted operations after flag qualification
    logic push;
    logic pop;

    assign push = wr_en && !full;
    assign pop  = read_en && !empty;

    // flags come straight from the occupancy count
    assign full  = (count == (ADDR_WIDTH + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    // head entry falls through to the reader without a read strobe
    assign read_data = mem[rd_ptr];

    // the array is written only on an accepted push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // write pointer moves past the slot just written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // read pointer advances on a pop so the next head shows a cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // count only moves when exactly one side is active
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/spi_fifo_pkg.sv */
/*
 * Shared widths, depth and types of the FIFO-fed SPI transmitter.
 * FIFO_DEPTH must stay a power of two because the FIFO pointers wrap
 * by plain overflow, and ADDR_WIDTH must equal its log2.
 * BIT_COUNT_WIDTH must be wide enough to hold DATA_WIDTH itself.
 */
`default_nettype none

package spi_fifo_pkg;

    // number of bits shifted out per word
    localparam int DATA_WIDTH = 8;

    // number of words the transmit FIFO can hold
    localparam int FIFO_DEPTH = 8;

    // read and write pointer width of the FIFO
    localparam int ADDR_WIDTH = 3;

    // the bit counter runs from DATA_WIDTH down to 0, so it needs one extra bit
    localparam int BIT_COUNT_WIDTH = 4;

    // one data word as written by the host and shifted onto mosi
    typedef logic [DATA_WIDTH-1:0] data_t;

    // serializer FSM states, encoded 0 to 4 in this order
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_EN,
        ST_LOAD,
        ST_SHIFT,
        ST_COMPLETE
    } serializer_state_t;

endpackage

`default_nettype wire
